//--- hw/xpu_pkg.sv
// shared widths, register offsets and version word for the xpu timing core, imported by all RTL
`default_nettype none

package xpu_pkg;

  // bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  localparam int TSF_W       = 64;  // 802.11 tsf is 64 bit
  localparam int SLICE_CNT_W = 20;  // microseconds per cycle / slice edge
  localparam int N_SLICES    = 4;

  typedef logic [SLICE_CNT_W-1:0]      slice_cnt_t;
  typedef logic [$clog2(N_SLICES)-1:0] slice_idx_t;
  typedef logic [TSF_W-1:0]            tsf_t;

  // word offsets, byte address is offset * 4
  localparam logic [5:0] REG_CTRL        = 6'd0;   // bit 0 slicer soft reset
  localparam logic [5:0] REG_TSF_LOAD_LO = 6'd2;
  localparam logic [5:0] REG_TSF_LOAD_HI = 6'd3;   // rising bit 31 loads timer
  localparam logic [5:0] REG_SLICE_TOTAL = 6'd20;
  localparam logic [5:0] REG_SLICE_START = 6'd21;
  localparam logic [5:0] REG_SLICE_END   = 6'd22;
  localparam logic [5:0] REG_TSF_RD_LO   = 6'd58;
  localparam logic [5:0] REG_TSF_RD_HI   = 6'd59;
  localparam logic [5:0] REG_VERSION     = 6'd63;

  // slice start/end word layout
  localparam int SLICE_IDX_LSB = 20;

  localparam logic [APB_DATA_W-1:0] XPU_VERSION = 32'h0001_0203;

endpackage

`default_nettype wire

//--- hw/xpu_regs.sv
// APB register block of the timing core that holds config and returns a coherent 64-bit tsf read
`default_nettype none
`timescale 1ns/1ps

module xpu_regs (
  input  wire                               clk_i,
  input  wire                               rst_n_i,
  input  wire                               psel_i,
  input  wire                               penable_i,
  input  wire                               pwrite_i,
  input  wire [xpu_pkg::APB_ADDR_W-1:0]     paddr_i,
  input  wire [xpu_pkg::APB_DATA_W-1:0]     pwdata_i,
  input  wire xpu_pkg::tsf_t                tsf_val_i,
  output logic [xpu_pkg::APB_DATA_W-1:0]    prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  output logic                              tsf_load_o,
  output xpu_pkg::tsf_t                     tsf_load_val_o,
  output xpu_pkg::slice_cnt_t               slice_total_o,
  output logic                              slice_wr_o,
  output logic [5:0]                        slice_sel_o,
  output xpu_pkg::slice_idx_t               slice_idx_o,
  output xpu_pkg::slice_cnt_t               slice_cnt_o,
  output logic                              slicer_srst_o
);

  import xpu_pkg::*;

  logic [5:0]            ofs;
  logic                  ofs_valid;
  logic                  wr_en;
  logic                  rd_lo_en;
  logic [APB_DATA_W-1:0] rd_mux;

  logic [APB_DATA_W-1:0] ctrl_q;
  logic [APB_DATA_W-1:0] load_lo_q;
  logic [APB_DATA_W-1:0] load_hi_q;
  logic [APB_DATA_W-1:0] total_q;
  logic [APB_DATA_W-1:0] start_q;   // last word written to SLICE_START
  logic [APB_DATA_W-1:0] end_q;
  logic [APB_DATA_W-1:0] tsf_hi_snap_q;
  logic                  load_bit_q;  // previous value of load_hi_q[31]

  assign ofs = paddr_i[APB_ADDR_W-1:2];  // word offset

  // read mux and offset decode
  always_comb begin
    ofs_valid = 1'b1;
    case (ofs)
      REG_CTRL:        rd_mux = ctrl_q;
      REG_TSF_LOAD_LO: rd_mux = load_lo_q;
      REG_TSF_LOAD_HI: rd_mux = load_hi_q;
      REG_SLICE_TOTAL: rd_mux = total_q;
      REG_SLICE_START: rd_mux = start_q;
      REG_SLICE_END:   rd_mux = end_q;
      REG_TSF_RD_LO:   rd_mux = tsf_val_i[APB_DATA_W-1:0];
      REG_TSF_RD_HI:   rd_mux = tsf_hi_snap_q;
      REG_VERSION:     rd_mux = XPU_VERSION;
      default: begin
        rd_mux    = '0;
        ofs_valid = 1'b0;
      end
    endcase
  end

  assign wr_en    = psel_i & penable_i & pwrite_i & ofs_valid;
  assign rd_lo_en = psel_i & penable_i & ~pwrite_i & (ofs == REG_TSF_RD_LO);

  assign prdata_o  = rd_mux;
  assign pready_o  = 1'b1;  // no wait states
  assign pslverr_o = psel_i & penable_i & ~ofs_valid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q        <= '0;
      load_lo_q     <= '0;
      load_hi_q     <= '0;
      total_q       <= '0;
      start_q       <= '0;
      end_q         <= '0;
      tsf_hi_snap_q <= '0;
      load_bit_q    <= 1'b0;
    end else begin
      load_bit_q <= load_hi_q[APB_DATA_W-1];
      if (rd_lo_en) begin
        tsf_hi_snap_q <= tsf_val_i[TSF_W-1:APB_DATA_W];  // pairs with the lo word just read
      end
      if (wr_en) begin
        case (ofs)
          REG_CTRL:        ctrl_q    <= pwdata_i;
          REG_TSF_LOAD_LO: load_lo_q <= pwdata_i;
          REG_TSF_LOAD_HI: load_hi_q <= pwdata_i;
          REG_SLICE_TOTAL: total_q   <= pwdata_i;
          REG_SLICE_START: start_q   <= pwdata_i;
          REG_SLICE_END:   end_q     <= pwdata_i;
          default: ;  // read-only words
        endcase
      end
    end
  end

  // timer load on rising edge of the msb
  assign tsf_load_o     = load_hi_q[APB_DATA_W-1] & ~load_bit_q;
  assign tsf_load_val_o = {1'b0, load_hi_q[APB_DATA_W-2:0], load_lo_q};

  // slicer config with table entries straight from the bus
  assign slice_total_o = total_q[SLICE_CNT_W-1:0];
  assign slice_wr_o    = wr_en & ((ofs == REG_SLICE_TOTAL) |
                                  (ofs == REG_SLICE_START) |
                                  (ofs == REG_SLICE_END));
  assign slice_sel_o   = ofs;
  assign slice_idx_o   = pwdata_i[SLICE_IDX_LSB +: $clog2(N_SLICES)];
  assign slice_cnt_o   = pwdata_i[SLICE_CNT_W-1:0];
  assign slicer_srst_o = ctrl_q[0];

  // every setup phase is followed by a completing access phase
  a_apb_no_wait: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (psel_i && !penable_i) |=> (psel_i && penable_i && pready_o)
  );

endmodule

`default_nettype wire

//--- hw/tsf_timer.sv
// 802.11 tsf timer, a microsecond prescaler and a loadable 64-bit counter of its ticks
`default_nettype none
`timescale 1ns/1ps

module tsf_timer #(
  parameter int CLK_PER_US = 50
) (
  input  wire                clk_i,
  input  wire                rst_n_i,
  input  wire                tsf_load_i,
  input  wire xpu_pkg::tsf_t tsf_load_val_i,
  output xpu_pkg::tsf_t      tsf_val_o,
  output logic               tsf_pulse_1m_o
);

  localparam int PRE_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(CLK_PER_US - 1);

  logic [PRE_W-1:0] pre_cnt_q;
  logic             pre_wrap;

  assign pre_wrap = (pre_cnt_q == PRE_LAST);

  // clock cycles within the current microsecond
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pre_cnt_q <= '0;
    end else if (tsf_load_i || pre_wrap) begin
      pre_cnt_q <= '0;
    end else begin
      pre_cnt_q <= pre_cnt_q + 1'b1;
    end
  end

  // one cycle tick per microsecond
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tsf_pulse_1m_o <= 1'b0;
    end else begin
      tsf_pulse_1m_o <= pre_wrap & ~tsf_load_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tsf_val_o <= '0;
    end else if (tsf_load_i) begin
      tsf_val_o <= tsf_load_val_i;  // load beats a pending tick
    end else if (tsf_pulse_1m_o) begin
      tsf_val_o <= tsf_val_o + 1'b1;
    end
  end

  // a load only ever delays the next tick
  a_tick_spacing: assert property (
    @(posedge clk_i) disable iff (!rst_n_i || tsf_load_i)
    tsf_pulse_1m_o |=> !tsf_pulse_1m_o [*CLK_PER_US-1]
  );

endmodule

`default_nettype wire

//--- hw/time_slice_gen.sv
// time-slice generator, splits a repeating microsecond cycle into four slice enable windows
`default_nettype none
`timescale 1ns/1ps

module time_slice_gen (
  input  wire                                 clk_i,
  input  wire                                 rst_n_i,
  input  wire                                 tsf_pulse_1m_i,
  input  wire xpu_pkg::slice_cnt_t            slice_total_i,
  input  wire                                 slice_wr_i,
  input  wire [5:0]                           slice_sel_i,
  input  wire xpu_pkg::slice_idx_t            slice_idx_i,
  input  wire xpu_pkg::slice_cnt_t            slice_cnt_i,
  input  wire                                 slicer_srst_i,
  output logic                                cycle_start_o,
  output logic [xpu_pkg::N_SLICES-1:0]        slice_en_o
);

  import xpu_pkg::*;

  slice_cnt_t            start_tab_q [N_SLICES];
  slice_cnt_t            end_tab_q   [N_SLICES];
  slice_cnt_t            cyc_cnt_q;
  logic                  enabled;
  logic                  restart;
  logic                  cyc_last;
  logic [N_SLICES-1:0]   win_hit;

  assign enabled  = (slice_total_i != '0);
  assign restart  = slice_wr_i | slicer_srst_i;
  assign cyc_last = (cyc_cnt_q == slice_total_i - 1'b1);

  // start and end tables, entry chosen by the index field
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < N_SLICES; i++) begin
        start_tab_q[i] <= '0;
        end_tab_q[i]   <= '0;
      end
    end else if (slice_wr_i) begin
      if (slice_sel_i == REG_SLICE_START) begin
        start_tab_q[slice_idx_i] <= slice_cnt_i;
      end
      if (slice_sel_i == REG_SLICE_END) begin
        end_tab_q[slice_idx_i] <= slice_cnt_i;
      end
    end
  end

  // microsecond position inside the cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc_cnt_q <= '0;
    end else if (restart || !enabled) begin
      cyc_cnt_q <= '0;
    end else if (tsf_pulse_1m_i) begin
      cyc_cnt_q <= cyc_last ? '0 : cyc_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_start_o <= 1'b0;
    end else begin
      cycle_start_o <= tsf_pulse_1m_i & enabled & cyc_last & ~restart;
    end
  end

  // start <= count < end
  always_comb begin
    for (int i = 0; i < N_SLICES; i++) begin
      win_hit[i] = enabled &
                   (cyc_cnt_q >= start_tab_q[i]) &
                   (cyc_cnt_q <  end_tab_q[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slice_en_o <= '0;
    end else begin
      slice_en_o <= win_hit;
    end
  end

  a_cycle_start_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cycle_start_o |=> !cycle_start_o
  );

  // a zero total keeps the slicer quiet
  a_cycle_start_needs_total: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(cycle_start_o) |-> enabled
  );

endmodule

`default_nettype wire

//--- hw/xpu_timing.sv
// top level of the timing core, APB registers beside the tsf timer and the time-slice generator
`default_nettype none
`timescale 1ns/1ps

module xpu_timing #(
  parameter int CLK_PER_US = 50
) (
  input  wire                               clk_i,
  input  wire                               rst_n_i,
  input  wire                               psel_i,
  input  wire                               penable_i,
  input  wire                               pwrite_i,
  input  wire [xpu_pkg::APB_ADDR_W-1:0]     paddr_i,
  input  wire [xpu_pkg::APB_DATA_W-1:0]     pwdata_i,
  output logic [xpu_pkg::APB_DATA_W-1:0]    prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  output xpu_pkg::tsf_t                     tsf_val_o,
  output logic                              tsf_pulse_1m_o,
  output logic                              cycle_start_o,
  output logic [xpu_pkg::N_SLICES-1:0]      slice_en_o
);

  import xpu_pkg::*;

  logic       tsf_load;
  tsf_t       tsf_load_val;
  slice_cnt_t slice_total;
  logic       slice_wr;
  logic [5:0] slice_sel;
  slice_idx_t slice_idx;
  slice_cnt_t slice_cnt;
  logic       slicer_srst;

  xpu_regs u_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .tsf_val_i      (tsf_val_o),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .tsf_load_o     (tsf_load),
    .tsf_load_val_o (tsf_load_val),
    .slice_total_o  (slice_total),
    .slice_wr_o     (slice_wr),
    .slice_sel_o    (slice_sel),
    .slice_idx_o    (slice_idx),
    .slice_cnt_o    (slice_cnt),
    .slicer_srst_o  (slicer_srst)
  );

  tsf_timer #(
    .CLK_PER_US (CLK_PER_US)
  ) u_tsf (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .tsf_load_i     (tsf_load),
    .tsf_load_val_i (tsf_load_val),
    .tsf_val_o      (tsf_val_o),
    .tsf_pulse_1m_o (tsf_pulse_1m_o)
  );

  time_slice_gen u_slice (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .tsf_pulse_1m_i (tsf_pulse_1m_o),
    .slice_total_i  (slice_total),
    .slice_wr_i     (slice_wr),
    .slice_sel_i    (slice_sel),
    .slice_idx_i    (slice_idx),
    .slice_cnt_i    (slice_cnt),
    .slicer_srst_i  (slicer_srst),
    .cycle_start_o  (cycle_start_o),
    .slice_en_o     (slice_en_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// testbench clock and reset source, free-running clock with reset held low for a few cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release just after a rising edge, same as the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_xpu_checker.sv
// testbench monitor that mirrors the APB config, models timer and slicer and compares outputs
`default_nettype none
`timescale 1ns/1ps

module tb_xpu_checker #(
  parameter int CLK_PER_US = 5
) (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            psel_i,
  input  wire                            penable_i,
  input  wire                            pwrite_i,
  input  wire [xpu_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  wire [xpu_pkg::APB_DATA_W-1:0]  pwdata_i,
  input  wire [xpu_pkg::APB_DATA_W-1:0]  prdata_i,
  input  wire                            pready_i,
  input  wire                            pslverr_i,
  input  wire xpu_pkg::tsf_t             tsf_val_i,
  input  wire                            tsf_pulse_1m_i,
  input  wire                            cycle_start_i,
  input  wire [xpu_pkg::N_SLICES-1:0]    slice_en_i,
  output int                             err_cnt_o
);

  import xpu_pkg::*;

  int          err_cnt = 0;
  logic        run_q;          // high once the first active edge has passed
  logic [31:0] regs_m [64];    // writable words by offset
  slice_cnt_t  start_m [N_SLICES];
  slice_cnt_t  end_m   [N_SLICES];
  slice_cnt_t  cnt_m;          // ticks since last slice write modulo total
  int          pre_m;
  logic        pulse_m;
  tsf_t        tsf_m;
  tsf_t        ld_val;
  logic        ld_pend;        // tsf load strobe high this cycle
  logic [31:0] snap_m;
  logic        wr_pend;        // write that lands at the next edge
  logic [5:0]  wr_ofs;
  logic [31:0] wr_data;

  assign err_cnt_o = err_cnt;

  // expected enable of one slice from the count held in the previous cycle
  function automatic logic slice_window_ref(input slice_cnt_t cnt, input slice_cnt_t total,
                                            input slice_cnt_t first, input slice_cnt_t last);
    return (total != 0) && (cnt >= first) && (cnt < last);
  endfunction

  // timer value after one clock edge where a load wins over a tick
  function automatic tsf_t tsf_next_ref(input tsf_t cur, input logic load,
                                        input tsf_t load_val, input logic tick);
    if (load) return load_val;
    if (tick) return cur + 1;
    return cur;
  endfunction

  function automatic logic is_mapped(input logic [5:0] ofs);
    case (ofs)
      REG_CTRL, REG_TSF_LOAD_LO, REG_TSF_LOAD_HI, REG_SLICE_TOTAL, REG_SLICE_START,
      REG_SLICE_END, REG_TSF_RD_LO, REG_TSF_RD_HI, REG_VERSION: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] read_ref(input logic [5:0] ofs);
    case (ofs)
      REG_TSF_RD_LO: return tsf_m[31:0];
      REG_TSF_RD_HI: return snap_m;
      REG_VERSION:   return XPU_VERSION;
      default:       return regs_m[ofs];
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic apply_write(input logic [5:0] ofs, input logic [31:0] data);
    if (ofs == REG_TSF_LOAD_HI && data[31] && !regs_m[REG_TSF_LOAD_HI][31]) begin
      ld_pend = 1'b1;  // strobe in the cycle after the write
      ld_val  = {1'b0, data[30:0], regs_m[REG_TSF_LOAD_LO]};
    end
    if (ofs == REG_SLICE_START) start_m[data[21:20]] = data[19:0];
    if (ofs == REG_SLICE_END) end_m[data[21:20]] = data[19:0];
    case (ofs)
      REG_CTRL, REG_TSF_LOAD_LO, REG_TSF_LOAD_HI, REG_SLICE_TOTAL, REG_SLICE_START,
      REG_SLICE_END: regs_m[ofs] = data;
      default: ;  // read-only words
    endcase
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // one model step per clock edge with outputs stable at the falling edge
  always @(negedge clk_i) begin
    logic                load_now;
    logic                tick_prev;
    logic                restart;
    logic                exp_cs;
    logic [N_SLICES-1:0] exp_en;
    logic [5:0]          ofs;
    slice_cnt_t          total;
    if (!run_q) begin
      for (int i = 0; i < 64; i++) begin
        regs_m[i] = '0;
      end
      for (int i = 0; i < N_SLICES; i++) begin
        start_m[i] = '0;
        end_m[i]   = '0;
      end
      cnt_m   = '0;
      pre_m   = 0;
      pulse_m = 1'b0;
      tsf_m   = '0;
      ld_val  = '0;
      ld_pend = 1'b0;
      snap_m  = '0;
      wr_pend = 1'b0;
    end else begin
      load_now  = ld_pend;
      tick_prev = pulse_m;
      ld_pend   = 1'b0;
      if (load_now) begin
        pre_m   = 0;  // prescaler restarts and the pending tick is dropped
        pulse_m = 1'b0;
      end else begin
        pulse_m = (pre_m == CLK_PER_US - 1);
        pre_m   = pulse_m ? 0 : pre_m + 1;
      end
      tsf_m = tsf_next_ref(tsf_m, load_now, ld_val, tick_prev);

      // slicer works on the config of the previous cycle
      total   = regs_m[REG_SLICE_TOTAL][SLICE_CNT_W-1:0];
      restart = (wr_pend && wr_ofs >= REG_SLICE_TOTAL && wr_ofs <= REG_SLICE_END) ||
                regs_m[REG_CTRL][0];
      exp_cs  = tick_prev && (total != 0) && (cnt_m == total - 1) && !restart;
      for (int i = 0; i < N_SLICES; i++) begin
        exp_en[i] = slice_window_ref(cnt_m, total, start_m[i], end_m[i]);
      end
      if (restart || total == 0) begin
        cnt_m = '0;
      end else if (tick_prev) begin
        cnt_m = (cnt_m == total - 1) ? '0 : cnt_m + 1'b1;
      end

      if (wr_pend) apply_write(wr_ofs, wr_data);
      wr_pend = 1'b0;

      check_value("tsf_val_o", tsf_m, tsf_val_i);
      check_value("tsf_pulse_1m_o", 64'(pulse_m), 64'(tsf_pulse_1m_i));
      check_value("cycle_start_o", 64'(exp_cs), 64'(cycle_start_i));
      check_value("slice_en_o", 64'(exp_en), 64'(slice_en_i));

      ofs = paddr_i[APB_ADDR_W-1:2];
      check_value("pslverr_o", 64'(psel_i && penable_i && !is_mapped(ofs)), 64'(pslverr_i));
      if (psel_i) check_value("pready_o", 64'd1, 64'(pready_i));
      if (psel_i && penable_i && is_mapped(ofs)) begin
        if (!pwrite_i) begin
          check_value("prdata_o", 64'(read_ref(ofs)), 64'(prdata_i));
          if (ofs == REG_TSF_RD_LO) snap_m = tsf_m[63:32];
        end else begin
          wr_pend = 1'b1;
          wr_ofs  = ofs;
          wr_data = pwdata_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_xpu_timing.sv
// testbench top for the timing core with APB driver, LFSR stimulus, watchdog and final verdict
`default_nettype none
`timescale 1ns/1ps

module tb_xpu_timing;

  import xpu_pkg::*;

  localparam int CLK_PER_US = 5;
  localparam int PERIOD_NS  = 20;
  localparam int DRIVE_NS   = 2;
  // worst case length of each test in clock cycles
  localparam int T_RESET  = 10;
  localparam int T_REGS   = 40;
  localparam int T_LOAD   = 150;
  localparam int T_READS  = 140;
  localparam int T_RANDOM = 1300;
  localparam int T_IDLE   = 170;
  localparam int T_SRST   = 320;
  localparam int T_SUM    = T_RESET + T_REGS + T_LOAD + T_READS + T_RANDOM + T_IDLE + T_SRST;
  localparam int WATCHDOG_NS = T_SUM * PERIOD_NS * 12 / 10;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  tsf_t                  tsf_val;
  logic                  tsf_pulse_1m;
  logic                  cycle_start;
  logic [N_SLICES-1:0]   slice_en;
  int                    err_cnt;
  logic [15:0]           lfsr_q = 16'd2453;

  tb_clk_gen #(
    .PERIOD_NS  (PERIOD_NS),
    .RST_CYCLES (5)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  xpu_timing #(
    .CLK_PER_US (CLK_PER_US)
  ) u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .tsf_val_o      (tsf_val),
    .tsf_pulse_1m_o (tsf_pulse_1m),
    .cycle_start_o  (cycle_start),
    .slice_en_o     (slice_en)
  );

  tb_xpu_checker #(
    .CLK_PER_US (CLK_PER_US)
  ) u_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_i       (prdata),
    .pready_i       (pready),
    .pslverr_i      (pslverr),
    .tsf_val_i      (tsf_val),
    .tsf_pulse_1m_i (tsf_pulse_1m),
    .cycle_start_i  (cycle_start),
    .slice_en_i     (slice_en),
    .err_cnt_o      (err_cnt)
  );

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // setup and access then one idle cycle
  task automatic apb_xfer(input logic write, input logic [5:0] ofs, input logic [31:0] data);
    @(posedge clk);
    #DRIVE_NS;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = {ofs, 2'b00};
    pwdata  = write ? data : '0;
    @(posedge clk);
    #DRIVE_NS;
    penable = 1'b1;
    @(posedge clk);
    #DRIVE_NS;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [5:0] ofs, input logic [31:0] data);
    apb_xfer(1'b1, ofs, data);
  endtask

  task automatic apb_read(input logic [5:0] ofs);
    apb_xfer(1'b0, ofs, '0);
  endtask

  task automatic read_tsf_pair();
    apb_read(REG_TSF_RD_LO);
    apb_read(REG_TSF_RD_HI);
  endtask

  task automatic wait_ticks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk);
      if (tsf_pulse_1m) seen++;
    end
  endtask

  task automatic random_slices();
    logic [31:0] r;
    slice_cnt_t  total;
    slice_cnt_t  a;
    slice_cnt_t  b;
    rand_bits(5, r);
    total = 20'd8 + r[19:0];
    apb_write(REG_SLICE_TOTAL, {12'd0, total});
    for (int i = 0; i < N_SLICES; i++) begin
      rand_bits(6, r);
      a = r[19:0] % (total + 1);
      rand_bits(6, r);
      b = r[19:0] % (total + 1);
      apb_write(REG_SLICE_START, {10'd0, 2'(i), (a < b) ? a : b});
      apb_write(REG_SLICE_END, {10'd0, 2'(i), (a < b) ? b : a});
    end
    wait_ticks(3 * total);
  endtask

  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    @(posedge rst_n);

    // register access and error response
    apb_read(REG_VERSION);
    apb_write(REG_SLICE_TOTAL, 32'hABC0_0011);
    apb_write(REG_CTRL, 32'h0000_5A50);
    apb_read(REG_SLICE_TOTAL);
    apb_read(REG_CTRL);
    apb_read(6'd10);
    apb_write(6'd41, 32'hDEAD_BEEF);
    apb_write(REG_VERSION, 32'h0);  // read-only
    apb_read(REG_VERSION);

    // load close to a low word carry and count across it
    apb_write(REG_TSF_LOAD_LO, 32'hFFFF_FFF2);
    apb_write(REG_TSF_LOAD_HI, 32'h8123_4567);
    wait_ticks(13);
    @(posedge clk);  // the carry now lands between the lo and the hi read
    read_tsf_pair();
    wait_ticks(7);
    read_tsf_pair();
    wait_ticks(13);
    read_tsf_pair();
    apb_write(REG_TSF_LOAD_HI, 32'h0123_4567);  // bit 31 low so no load
    apb_write(REG_TSF_LOAD_LO, 32'h0000_0100);
    apb_write(REG_TSF_LOAD_HI, 32'h8000_0002);
    read_tsf_pair();

    repeat (2) random_slices();

    apb_write(REG_SLICE_TOTAL, 32'd0);
    wait_ticks(30);

    // soft reset holds the slicer at count 0
    apb_write(REG_SLICE_TOTAL, 32'd12);
    wait_ticks(17);
    apb_write(REG_CTRL, 32'h0000_5A51);
    wait_ticks(5);
    apb_write(REG_CTRL, 32'h0000_5A50);
    wait_ticks(36);

    repeat (4) @(posedge clk);
    $display("all tests done, %0d error(s) counted", err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hw/xpu_pkg.sv
hw/xpu_regs.sv
hw/tsf_timer.sv
hw/time_slice_gen.sv
hw/xpu_timing.sv
testbench/tb_clk_gen.sv
testbench/tb_xpu_checker.sv
testbench/tb_xpu_timing.sv

//--- Bender.yml
package:
  name: xpu_timing

sources:
  - hw/xpu_pkg.sv
  - hw/xpu_regs.sv
  - hw/tsf_timer.sv
  - hw/time_slice_gen.sv
  - hw/xpu_timing.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_xpu_checker.sv
      - testbench/tb_xpu_timing.sv
